//--- hw/tile_pkg.sv
/*
  Shared widths and types of the tile subsystem.
  APB address: bits 11..10 tile window, bits 9..2 word index, bits 1..0 ignored.
  Only windows below NumMemTiles are backed by a memory tile.
*/

package tile_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned AddrWidth    = 12;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned NumMemTiles  = 2;
  localparam int unsigned TileWords    = 256;
  localparam int unsigned WordIdxWidth = 8;

  ////////////////////
  // Types
  ////////////////////

  // APB byte address
  typedef logic [AddrWidth-1:0]    apb_addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  // Word index inside one tile
  typedef logic [WordIdxWidth-1:0] word_idx_t;
  // Top address bits, one window per tile
  typedef logic [1:0]              tile_sel_t;

  // Host tile FSM
  typedef enum logic [1:0] {
    HOST_IDLE,
    HOST_REQ,
    HOST_WAIT,
    HOST_DONE
  } host_state_e;

endpackage

//--- hw/tile_link_if.sv
/*
  Request and response link between the host tile and one memory tile.
  Both channels use valid/ready; a raised valid holds with a stable payload.
  Every request gets exactly one response, writes return zero data.
*/
`timescale 1ns/1ps

interface tile_link_if
  import tile_pkg::*;
();

  // Request channel
  logic      req_valid;
  logic      req_ready;
  logic      req_write;
  word_idx_t req_idx;
  data_t     req_wdata;

  // Response channel
  logic      rsp_valid;
  logic      rsp_ready;
  data_t     rsp_rdata;

  modport initiator (
    output req_valid,
    output req_write,
    output req_idx,
    output req_wdata,
    input  req_ready,
    input  rsp_valid,
    input  rsp_rdata,
    output rsp_ready
  );

  modport target (
    input  req_valid,
    input  req_write,
    input  req_idx,
    input  req_wdata,
    output req_ready,
    output rsp_valid,
    output rsp_rdata,
    input  rsp_ready
  );

endinterface

//--- hw/host_tile.sv
/*
  APB slave of the tile subsystem; one transfer in flight at a time.
  Mapped windows go out on their own link, pready comes after the response.
  Unmapped windows finish in the second access cycle with pslverr, no side effect.
  No write strobes or protection bits: every write stores a full word.
*/
`timescale 1ns/1ps

module host_tile
  import tile_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_n_i,
  // APB slave
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           pwrite_i,
  input  apb_addr_t      paddr_i,
  input  data_t          pwdata_i,
  output data_t          prdata_o,
  output logic           pready_o,
  output logic           pslverr_o,
  // Links to the memory tiles
  tile_link_if.initiator link0_o,
  tile_link_if.initiator link1_o
);

  host_state_e state_q;

  // Captured transfer
  tile_sel_t   sel_q;
  word_idx_t   idx_q;
  logic        write_q;
  data_t       wdata_q;

  // Completion
  logic        err_q;
  data_t       prdata_q;

  tile_sel_t   apb_sel;
  logic        apb_mapped;

  // Handshake of the selected link
  logic        sel_req_ready;
  logic        sel_rsp_valid;
  data_t       sel_rsp_rdata;

  ////////////////////
  // Address decode
  ////////////////////

  assign apb_sel    = paddr_i[AddrWidth-1 -: $bits(tile_sel_t)];
  assign apb_mapped = apb_sel < tile_sel_t'(NumMemTiles);

  // Only the selected link is looked at
  always_comb begin
    sel_req_ready = 1'b0;
    sel_rsp_valid = 1'b0;
    sel_rsp_rdata = '0;
    case (sel_q)
      2'd0: begin
        sel_req_ready = link0_o.req_ready;
        sel_rsp_valid = link0_o.rsp_valid;
        sel_rsp_rdata = link0_o.rsp_rdata;
      end
      2'd1: begin
        sel_req_ready = link1_o.req_ready;
        sel_rsp_valid = link1_o.rsp_valid;
        sel_rsp_rdata = link1_o.rsp_rdata;
      end
      default: begin
        sel_req_ready = 1'b0;
      end
    endcase
  end

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= HOST_IDLE;
      err_q    <= 1'b0;
      prdata_q <= '0;
    end else begin
      case (state_q)
        HOST_IDLE: begin
          // First access cycle of a transfer
          if (psel_i && penable_i) begin
            if (apb_mapped) begin
              state_q <= HOST_REQ;
            end else begin
              state_q  <= HOST_DONE;
              err_q    <= 1'b1;
              prdata_q <= '0;
            end
          end
        end
        HOST_REQ: begin
          if (sel_req_ready) begin
            state_q <= HOST_WAIT;
          end
        end
        HOST_WAIT: begin
          if (sel_rsp_valid) begin
            state_q  <= HOST_DONE;
            prdata_q <= sel_rsp_rdata;
          end
        end
        HOST_DONE: begin
          state_q <= HOST_IDLE;
          err_q   <= 1'b0;
        end
        default: begin
          state_q <= HOST_IDLE;
        end
      endcase
    end
  end

  // Transfer payload, taken once per transfer
  always_ff @(posedge clk_i) begin
    if (state_q == HOST_IDLE && psel_i && penable_i) begin
      sel_q   <= apb_sel;
      idx_q   <= paddr_i[AddrWidth-$bits(tile_sel_t)-1 -: WordIdxWidth];
      write_q <= pwrite_i;
      wdata_q <= pwdata_i;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign pready_o  = (state_q == HOST_DONE);
  assign pslverr_o = err_q;
  assign prdata_o  = prdata_q;

  assign link0_o.req_valid = (state_q == HOST_REQ) && (sel_q == 2'd0);
  assign link0_o.req_write = write_q;
  assign link0_o.req_idx   = idx_q;
  assign link0_o.req_wdata = wdata_q;
  assign link0_o.rsp_ready = (state_q == HOST_WAIT) && (sel_q == 2'd0);

  assign link1_o.req_valid = (state_q == HOST_REQ) && (sel_q == 2'd1);
  assign link1_o.req_write = write_q;
  assign link1_o.req_idx   = idx_q;
  assign link1_o.req_wdata = wdata_q;
  assign link1_o.rsp_ready = (state_q == HOST_WAIT) && (sel_q == 2'd1);

endmodule

//--- hw/mem_tile.sv
/*
  Link target with a word-addressed scratchpad of TileWords words.
  Storage has no reset; read data of unwritten words is undefined.
  One response slot: no new request is taken while a response waits.
*/
`timescale 1ns/1ps

module mem_tile
  import tile_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  tile_link_if.target link_i
);

  data_t mem_q [TileWords];

  // Response slot
  logic  rsp_valid_q;
  data_t rsp_rdata_q;

  logic  req_fire;
  logic  rsp_fire;

  ////////////////////
  // Handshakes
  ////////////////////

  // Back-pressure while the slot is full
  assign link_i.req_ready = !rsp_valid_q;

  assign req_fire = link_i.req_valid && link_i.req_ready;
  assign rsp_fire = rsp_valid_q && link_i.rsp_ready;

  ////////////////////
  // Scratchpad
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (req_fire && link_i.req_write) begin
      mem_q[link_i.req_idx] <= link_i.req_wdata;
    end
  end

  // Read data sampled at the accepting edge, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (link_i.req_write) begin
        rsp_rdata_q <= '0;
      end else begin
        rsp_rdata_q <= mem_q[link_i.req_idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_fire) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign link_i.rsp_valid = rsp_valid_q;
  assign link_i.rsp_rdata = rsp_rdata_q;

endmodule

//--- hw/tile_mesh_top.sv
/*
  Top level: APB host tile and two memory tiles on point-to-point links.
  Window 0 is tile 0, window 1 is tile 1, windows 2 and 3 answer pslverr.
  No mesh router, interrupts, debug or peripheral I/O.
*/
`timescale 1ns/1ps

module tile_mesh_top
  import tile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // APB slave
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  data_t     pwdata_i,
  output data_t     prdata_o,
  output logic      pready_o,
  output logic      pslverr_o
);

  tile_link_if link0 ();
  tile_link_if link1 ();

  ////////////////////
  // Host tile
  ////////////////////

  host_tile i_host_tile (
    .clk_i,
    .rst_n_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .link0_o  (link0.initiator),
    .link1_o  (link1.initiator)
  );

  ////////////////////
  // Memory tiles
  ////////////////////

  mem_tile i_mem_tile_0 (
    .clk_i,
    .rst_n_i,
    .link_i (link0.target)
  );

  mem_tile i_mem_tile_1 (
    .clk_i,
    .rst_n_i,
    .link_i (link1.target)
  );

endmodule

//--- sim/tb_tile_mesh_top.sv
/*
  Testbench for the tile subsystem: APB master, reference memory model, compare process.
  Model words that were never written are not checked on read.
  Random traffic uses a fixed seed and a narrow word index range.
*/
`timescale 1ns/1ps

module tb_tile_mesh_top
  import tile_pkg::*;
();

  // Full sequence runs about 1400 cycles
  localparam int MaxCycles = 4000;
  localparam int NumRandom = 200;

  logic      clk_i;
  logic      rst_n_i;
  logic      psel_i;
  logic      penable_i;
  logic      pwrite_i;
  apb_addr_t paddr_i;
  data_t     pwdata_i;
  data_t     prdata_o;
  logic      pready_o;
  logic      pslverr_o;

  // Reference model, one row per mapped window
  data_t ref_mem   [NumMemTiles][TileWords];
  logic  ref_known [NumMemTiles][TileWords];

  // Expected completion of the transfer in flight
  logic  exp_pending;
  logic  exp_check;
  logic  exp_err;
  data_t exp_data;

  string       cur_test;
  int          test_errors;
  int          total_errors;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count = 0;
  integer      seed;
  logic [31:0] rnd;
  apb_addr_t   rnd_addr;
  data_t       rnd_data;

  tile_mesh_top i_tile_mesh_top (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic apb_addr_t tile_addr(input tile_sel_t window, input word_idx_t idx);
    return {window, idx, 2'b00};
  endfunction

  // Windows 0 and 1 have a memory tile, 2 and 3 do not
  function automatic logic is_mapped(input apb_addr_t addr);
    return addr[11] == 1'b0;
  endfunction

  // Unmapped windows read as zero with an error
  function automatic data_t ref_read(input apb_addr_t addr, output logic err,
                                     output logic known);
    err   = 1'b0;
    known = 1'b1;
    if (!is_mapped(addr)) begin
      err = 1'b1;
      return '0;
    end
    known = ref_known[addr[10]][addr[9:2]];
    return ref_mem[addr[10]][addr[9:2]];
  endfunction

  task automatic store_expected(input apb_addr_t addr, input data_t data);
    if (is_mapped(addr)) begin
      ref_mem[addr[10]][addr[9:2]]   = data;
      ref_known[addr[10]][addr[9:2]] = 1'b1;
    end
  endtask

  ////////////////////
  // APB master
  ////////////////////

  task automatic apb_transfer(input logic write, input apb_addr_t addr, input data_t wdata);
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    @(negedge clk_i);
    while (pready_o !== 1'b1) @(negedge clk_i);
    // Hold through the completing edge
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // Writes answer with zero data
  task automatic apb_write(input apb_addr_t addr, input data_t data);
    exp_err     = !is_mapped(addr);
    exp_data    = '0;
    exp_check   = 1'b1;
    exp_pending = 1'b1;
    apb_transfer(1'b1, addr, data);
    store_expected(addr, data);
  endtask

  task automatic apb_read(input apb_addr_t addr);
    logic err;
    logic known;
    exp_data    = ref_read(addr, err, known);
    exp_err     = err;
    exp_check   = known || err;
    exp_pending = 1'b1;
    apb_transfer(1'b0, addr, '0);
  endtask

  ////////////////////
  // Checking
  ////////////////////

  task automatic count_error();
    test_errors  = test_errors + 1;
    total_errors = total_errors + 1;
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic close_test();
    if (test_errors == 0) begin
      $display("Test %s passed", cur_test);
      tests_passed = tests_passed + 1;
    end else begin
      $display("Test %s failed with %0d errors", cur_test, test_errors);
      tests_failed = tests_failed + 1;
    end
  endtask

  task automatic check_outputs_idle();
    if (pready_o !== 1'b0) begin
      $display("Fail %s: pready expected 0 actual %b", cur_test, pready_o);
      count_error();
    end
    if (pslverr_o !== 1'b0) begin
      $display("Fail %s: pslverr expected 0 actual %b", cur_test, pslverr_o);
      count_error();
    end
    if (prdata_o !== '0) begin
      $display("Fail %s: prdata expected 00000000 actual %08h", cur_test, prdata_o);
      count_error();
    end
  endtask

  // One completion per pready cycle
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1 && pready_o === 1'b1) begin
      if (!exp_pending) begin
        $display("Error in %s: pready was high with no transfer in flight", cur_test);
        count_error();
      end else begin
        if (pslverr_o !== exp_err) begin
          $display("Fail %s: pslverr expected %b actual %b at paddr %03h",
                   cur_test, exp_err, pslverr_o, paddr_i);
          count_error();
        end
        if (exp_check && prdata_o !== exp_data) begin
          $display("Fail %s: prdata expected %08h actual %08h at paddr %03h",
                   cur_test, exp_data, prdata_o, paddr_i);
          count_error();
        end
        exp_pending = 1'b0;
      end
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    rst_n_i      = 1'b0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    exp_pending  = 1'b0;
    exp_check    = 1'b0;
    exp_err      = 1'b0;
    exp_data     = '0;
    total_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    seed         = 53;
    for (int t = 0; t < NumMemTiles; t++) begin
      for (int w = 0; w < TileWords; w++) begin
        ref_known[t][w] = 1'b0;
      end
    end

    start_test("reset_state");
    repeat (8) begin
      @(negedge clk_i);
      check_outputs_idle();
    end
    rst_n_i = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_outputs_idle();
    end
    close_test();

    start_test("single_tile");
    for (int i = 0; i < 8; i++) begin
      apb_write(tile_addr(2'd0, word_idx_t'(i)), 32'h1000_0000 + i * 32'h0101_0101);
    end
    for (int i = 0; i < 8; i++) begin
      apb_read(tile_addr(2'd0, word_idx_t'(i)));
    end
    close_test();

    start_test("both_windows");
    apb_write(tile_addr(2'd0, 8'd10), 32'h0000_aaaa);
    apb_write(tile_addr(2'd1, 8'd10), 32'h5555_0000);
    apb_write(tile_addr(2'd1, 8'd200), 32'h1234_5678);
    apb_write(tile_addr(2'd0, 8'd200), 32'h8765_4321);
    apb_read(tile_addr(2'd0, 8'd10));
    apb_read(tile_addr(2'd1, 8'd10));
    apb_read(tile_addr(2'd0, 8'd200));
    apb_read(tile_addr(2'd1, 8'd200));
    close_test();

    start_test("unmapped_windows");
    apb_write(tile_addr(2'd2, 8'd3), 32'hdead_beef);
    apb_write(tile_addr(2'd3, 8'd10), 32'hcafe_f00d);
    apb_read(tile_addr(2'd2, 8'd3));
    apb_read(tile_addr(2'd3, 8'd10));
    // Same indices in the mapped windows stay as they were
    apb_read(tile_addr(2'd0, 8'd3));
    apb_read(tile_addr(2'd0, 8'd10));
    apb_read(tile_addr(2'd1, 8'd10));
    close_test();

    start_test("random_traffic");
    for (int n = 0; n < NumRandom; n++) begin
      rnd = $random(seed);
      // Narrow index range so reads hit written words
      rnd_addr = {1'b0, rnd[0], 3'b000, rnd[5:1], rnd[7:6]};
      rnd_data = $random(seed);
      if (rnd[8]) begin
        apb_write(rnd_addr, rnd_data);
      end else begin
        apb_read(rnd_addr);
      end
    end
    close_test();

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
hw/tile_pkg.sv
hw/tile_link_if.sv
hw/host_tile.sv
hw/mem_tile.sv
hw/tile_mesh_top.sv
sim/tb_tile_mesh_top.sv

//--- run.sh
#!/bin/sh
# Compile and run the tile subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f \
  --top-module tb_tile_mesh_top \
  -Mdir obj_dir -o sim_tile_mesh

./obj_dir/sim_tile_mesh | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "Result: PASS"
  exit 0
else
  echo "Result: FAIL"
  exit 1
fi
